/* head_tile.f */
rtl/head_pkg.sv
rtl/cfg_retime.sv
rtl/head_mem_axil.sv
rtl/head_sram.sv
rtl/head_sram_rd_ctrl.sv
rtl/abuf_feed.sv
rtl/op_finish.sv
rtl/head_tile.sv
tb/tb_head_tile.sv

/* rtl/abuf_feed.sv */
/*
 * registered source select for the activation link
 * global sram rows take priority over head sram rows
 */
`timescale 1ns/1ps

module abuf_feed (
    input  logic               clk,
    input  logic               rst_n,
    input  head_pkg::sram_rd_t global_rd,
    input  head_pkg::sram_rd_t sram_rd,
    output head_pkg::sram_rd_t hlink_out
);

    import head_pkg::*;

    row_t data_q;
    logic vld_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= global_rd.vld || sram_rd.vld;
        end
    end

    always_ff @(posedge clk) begin
        if (global_rd.vld) begin
            data_q <= global_rd.data;  // a head sram row in the same cycle is dropped
        end else if (sram_rd.vld) begin
            data_q <= sram_rd.data;
        end
    end

    assign hlink_out.data = data_q;
    assign hlink_out.vld  = vld_q;

endmodule

/* rtl/cfg_retime.sv */
/*
 * one-cycle retiming register for a valid-qualified payload
 * the payload holds between updates, only the valid bit drops
 */
`timescale 1ns/1ps

module cfg_retime #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_vld,
    input  payload_t in_data,
    output logic     out_vld,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld  <= 1'b0;
            out_data <= '0;
        end else begin
            out_vld <= in_vld;
            if (in_vld) begin
                out_data <= in_data;  // held otherwise
            end
        end
    end

endmodule

/* rtl/head_mem_axil.sv */
/*
 * AXI4-Lite slave giving the host row access to the head sram
 * one outstanding write and one outstanding read, always an OKAY response
 */
`timescale 1ns/1ps

module head_mem_axil (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [head_pkg::axil_addr_width-1:0] s_awaddr,
    input  logic                                 s_awvalid,
    output logic                                 s_awready,
    input  head_pkg::row_t                       s_wdata,
    input  logic                                 s_wvalid,
    output logic                                 s_wready,
    output logic [1:0]                           s_bresp,
    output logic                                 s_bvalid,
    input  logic                                 s_bready,
    input  logic [head_pkg::axil_addr_width-1:0] s_araddr,
    input  logic                                 s_arvalid,
    output logic                                 s_arready,
    output head_pkg::row_t                       s_rdata,
    output logic [1:0]                           s_rresp,
    output logic                                 s_rvalid,
    input  logic                                 s_rready,
    output logic [head_pkg::row_addr_width-1:0]  host_addr,
    output logic                                 host_wen,
    output head_pkg::row_t                       host_wdata,
    output logic                                 host_ren,
    input  head_pkg::row_t                       host_rdata
);

    import head_pkg::*;

    logic wr_go;    // aw and w taken together
    logic rd_go;
    logic rd_pend;  // sram read in flight

    ////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////

    assign wr_go = s_awvalid && s_wvalid && !s_bvalid;
    // the sram host port is shared, a write takes it first
    assign rd_go = s_arvalid && !rd_pend && !s_rvalid && !wr_go;

    assign s_awready = wr_go;
    assign s_wready  = wr_go;
    assign s_arready = rd_go;
    assign s_bresp   = axil_resp_okay;
    assign s_rresp   = axil_resp_okay;

    // row index sits above the byte lanes
    assign host_addr  = wr_go ? s_awaddr[2 +: row_addr_width] : s_araddr[2 +: row_addr_width];
    assign host_wen   = wr_go;
    assign host_wdata = s_wdata;
    assign host_ren   = rd_go;

    ////////////////////////////////////////
    // responses
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_bvalid <= 1'b0;
            rd_pend  <= 1'b0;
            s_rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
            rd_pend <= rd_go;
            if (rd_pend) begin
                s_rvalid <= 1'b1;  // sram data arrives now
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            s_rdata <= host_rdata;
        end
    end

endmodule

/* rtl/head_pkg.sv */
/*
 * shared sizes, control state encoding and bundled signal types of the head tile
 * imported by every module that handles rows, bus writes or the control state
 */
package head_pkg;

    localparam int lane_num        = 4;
    localparam int idata_width     = 8;
    localparam int row_width       = lane_num * idata_width;  // 32
    localparam int sram_depth      = 64;
    localparam int row_addr_width  = 6;
    localparam int lane_addr_width = 2;
    localparam int elem_addr_width = row_addr_width + lane_addr_width;
    localparam int row_cnt_width   = 7;  // counts up to a full sram
    localparam int axil_addr_width = 8;

    localparam logic [1:0] axil_resp_okay = 2'b00;

    typedef logic [row_width-1:0] row_t;

    // idle must stay the zero encoding, reset relies on it
    typedef enum logic [3:0] {
        idle   = 4'd0,
        q_gen  = 4'd1,
        k_gen  = 4'd2,
        v_gen  = 4'd3,
        att_qk = 4'd4,
        att_pv = 4'd5,
        proj   = 4'd6,
        ffn0   = 4'd7,
        ffn1   = 4'd8
    } control_state_t;

    typedef struct packed {
        control_state_t state;
        logic           update;
        logic           start;
    } op_ctrl_t;

    typedef struct packed {
        logic [row_addr_width-1:0] base_row;
        logic [row_cnt_width-1:0]  row_cnt;
    } rd_cfg_t;

    typedef struct packed {
        logic                       wen;
        logic                       hs_bias;  // selects the head sram
        logic [elem_addr_width-1:0] addr;     // row and lane
        logic [idata_width-1:0]     data;
    } gbus_wr_t;

    typedef struct packed {
        row_t data;
        logic vld;
    } sram_rd_t;

endpackage

/* rtl/head_sram.sv */
/*
 * row storage of the head: host row port, single-element bus writes, streaming reads
 * an element write replaces one lane, with ReLU applied in the ffn0 state
 */
`timescale 1ns/1ps

module head_sram (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [head_pkg::row_addr_width-1:0] host_addr,
    input  logic                                host_wen,
    input  head_pkg::row_t                      host_wdata,
    input  logic                                host_ren,
    output head_pkg::row_t                      host_rdata,
    input  head_pkg::gbus_wr_t                  elem_wr,
    input  head_pkg::control_state_t            state,
    input  logic                                rd_en,
    input  logic [head_pkg::row_addr_width-1:0] rd_addr,
    output head_pkg::sram_rd_t                  rd_out
);

    import head_pkg::*;

    row_t                       mem [sram_depth];
    logic                       elem_wen;
    logic [row_addr_width-1:0]  elem_row;
    logic [lane_addr_width-1:0] elem_lane;
    logic [idata_width-1:0]     elem_data;
    row_t                       rd_data_q;
    logic                       rd_vld_q;

    assign elem_wen  = elem_wr.wen && elem_wr.hs_bias;
    assign elem_row  = elem_wr.addr[elem_addr_width-1:lane_addr_width];
    assign elem_lane = elem_wr.addr[lane_addr_width-1:0];

    // relu, negative elements stored as zero
    assign elem_data = (state == ffn0 && elem_wr.data[idata_width-1]) ? '0 : elem_wr.data;

    ////////////////////////////////////////
    // writes
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (host_wen) begin
            mem[host_addr] <= host_wdata;
        end
        // later assignment, so the element lane beats a host write to the same row
        for (int l = 0; l < lane_num; l++) begin
            if (elem_wen && int'(elem_lane) == l) begin
                mem[elem_row][l*idata_width +: idata_width] <= elem_data;
            end
        end
    end

    ////////////////////////////////////////
    // reads, one cycle
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (host_ren) begin
            host_rdata <= mem[host_addr];
        end
        if (rd_en) begin
            rd_data_q <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= rd_en;
        end
    end

    assign rd_out.data = rd_data_q;
    assign rd_out.vld  = rd_vld_q;

endmodule

/* rtl/head_sram_rd_ctrl.sv */
/*
 * walks the configured row range of the head sram, one read per cycle
 * done pulses the cycle after the last read, or right after start for a zero count
 */
`timescale 1ns/1ps

module head_sram_rd_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  head_pkg::rd_cfg_t                   rd_cfg,
    output logic                                rd_en,
    output logic [head_pkg::row_addr_width-1:0] rd_addr,
    output logic                                done
);

    import head_pkg::*;

    logic [row_cnt_width-1:0] remain;  // reads left after the current one

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en   <= 1'b0;
            rd_addr <= '0;
            remain  <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rd_en) begin
                // busy, a new start is dropped
                if (remain == '0) begin
                    rd_en <= 1'b0;
                    done  <= 1'b1;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                    remain  <= remain - 1'b1;
                end
            end else if (start) begin
                if (rd_cfg.row_cnt == '0) begin
                    done <= 1'b1;  // nothing to read
                end else begin
                    rd_en   <= 1'b1;
                    rd_addr <= rd_cfg.base_row;
                    remain  <= rd_cfg.row_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/head_tile.sv */
/*
 * attention head tile, memory and sequencing path only
 * host AXI4-Lite port, bus element writes, row streaming to the activation link
 */
`timescale 1ns/1ps

module head_tile (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [head_pkg::axil_addr_width-1:0] s_awaddr,
    input  logic                                 s_awvalid,
    output logic                                 s_awready,
    input  head_pkg::row_t                       s_wdata,
    input  logic                                 s_wvalid,
    output logic                                 s_wready,
    output logic [1:0]                           s_bresp,
    output logic                                 s_bvalid,
    input  logic                                 s_bready,
    input  logic [head_pkg::axil_addr_width-1:0] s_araddr,
    input  logic                                 s_arvalid,
    output logic                                 s_arready,
    output head_pkg::row_t                       s_rdata,
    output logic [1:0]                           s_rresp,
    output logic                                 s_rvalid,
    input  logic                                 s_rready,
    input  head_pkg::op_ctrl_t                   op_ctrl_in,
    input  logic                                 rd_cfg_vld,
    input  head_pkg::rd_cfg_t                    rd_cfg_in,
    input  head_pkg::gbus_wr_t                   gbus_in,
    input  head_pkg::sram_rd_t                   global_rd,
    output head_pkg::sram_rd_t                   hlink_out,
    output head_pkg::gbus_wr_t                   gbus_out,
    output logic                                 finish
);

    import head_pkg::*;

    logic                      ctrl_vld_in;
    logic                      ctrl_vld_q;
    op_ctrl_t                  ctrl_q;
    logic                      start_q;  // retimed start pulse
    rd_cfg_t                   rd_cfg_q;
    logic [row_addr_width-1:0] host_addr;
    logic                      host_wen;
    row_t                      host_wdata;
    logic                      host_ren;
    row_t                      host_rdata;
    logic                      rd_en;
    logic [row_addr_width-1:0] rd_addr;
    sram_rd_t                  sram_rd;
    logic                      rd_done;

    ////////////////////////////////////////
    // control retiming
    ////////////////////////////////////////

    assign ctrl_vld_in = op_ctrl_in.update || op_ctrl_in.start;
    assign start_q     = ctrl_vld_q && ctrl_q.start;  // payload holds, so qualify

    cfg_retime #(.payload_t(op_ctrl_t)) i_ctrl_retime (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (ctrl_vld_in),
        .in_data  (op_ctrl_in),
        .out_vld  (ctrl_vld_q),
        .out_data (ctrl_q)
    );

    cfg_retime #(.payload_t(rd_cfg_t)) i_rd_cfg_retime (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_vld   (rd_cfg_vld),
        .in_data  (rd_cfg_in),
        .out_vld  (),
        .out_data (rd_cfg_q)
    );

    ////////////////////////////////////////
    // head sram and its ports
    ////////////////////////////////////////

    head_mem_axil i_head_mem_axil (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_awaddr   (s_awaddr),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_wdata    (s_wdata),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_bresp    (s_bresp),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_araddr   (s_araddr),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .host_addr  (host_addr),
        .host_wen   (host_wen),
        .host_wdata (host_wdata),
        .host_ren   (host_ren),
        .host_rdata (host_rdata)
    );

    head_sram i_head_sram (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_addr  (host_addr),
        .host_wen   (host_wen),
        .host_wdata (host_wdata),
        .host_ren   (host_ren),
        .host_rdata (host_rdata),
        .elem_wr    (gbus_in),
        .state      (ctrl_q.state),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_out     (sram_rd)
    );

    head_sram_rd_ctrl i_head_sram_rd_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start_q),
        .rd_cfg  (rd_cfg_q),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .done    (rd_done)
    );

    ////////////////////////////////////////
    // activation feed and finish
    ////////////////////////////////////////

    abuf_feed i_abuf_feed (
        .clk       (clk),
        .rst_n     (rst_n),
        .global_rd (global_rd),
        .sram_rd   (sram_rd),
        .hlink_out (hlink_out)
    );

    op_finish i_op_finish (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (ctrl_q.state),
        .rd_done  (rd_done),
        .gbus_in  (gbus_in),
        .gbus_out (gbus_out),
        .finish   (finish)
    );

endmodule

/* rtl/op_finish.sv */
/*
 * delays the global bus write by one cycle and produces the finish pulse
 * in bus-writing states finish waits until the delayed bus goes idle
 */
`timescale 1ns/1ps

module op_finish (
    input  logic                     clk,
    input  logic                     rst_n,
    input  head_pkg::control_state_t state,
    input  logic                     rd_done,
    input  head_pkg::gbus_wr_t       gbus_in,
    output head_pkg::gbus_wr_t       gbus_out,
    output logic                     finish
);

    import head_pkg::*;

    logic done_flag;
    logic bus_state;  // states whose results go out over the bus
    logic finish_ok;

    assign bus_state = (state == att_qk) || (state == att_pv) || (state == ffn0) ||
                       (state == proj) || (state == ffn1);

    assign finish_ok = done_flag && !(bus_state && gbus_out.wen);

    ////////////////////////////////////////
    // bus delay and finish
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gbus_out  <= '0;
            done_flag <= 1'b0;
            finish    <= 1'b0;
        end else begin
            gbus_out <= gbus_in;
            if (finish) begin
                done_flag <= 1'b0;  // one pulse per operation
                finish    <= 1'b0;
            end else begin
                finish <= finish_ok;
                if (rd_done) begin
                    done_flag <= 1'b1;
                end
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the head tile testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_head_tile -f head_tile.f \
    -Mdir obj_dir -o tb_head_tile
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_head_tile > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

/* tb/head_tile_tests.txt */
# head tile test commands, one per line, fields a b c in hex
# W row data bstall | R row expect rstall | S state 0 0 | E elem_addr data sel
# O base count busy | G row_data 0 0
W 00 11223344 0
W 01 a5a5a5a5 3
W 02 ffffffff 0
W 03 0f0f0f0f 5
R 01 a5a5a5a5 0
R 00 11223344 4
S 1 0 0
E 05 9c 1
E 0e 77 0
R 01 a5a59ca5 0
R 03 0f0f0f0f 2
S 7 0 0
E 08 f0 1
E 0b 35 1
R 02 35ffff00 0
S 1 0 0
O 00 4 0
G cafef00d 0 0
S 4 0 0
O 01 2 c
O 00 0 0

/* tb/tb_head_tile.sv */
/*
 * testbench for the head tile that runs the commands of tb/head_tile_tests.txt
 * keeps a row model of the head sram and checks host reads, hlink rows and finish
 */
`timescale 1ns/1ps

module tb_head_tile;

    import head_pkg::*;

    localparam int hs_timeout = 50;   // cycles per handshake wait
    localparam int op_timeout = 300;  // cycles until finish

    logic                       clk;
    logic                       rst_n;
    logic [axil_addr_width-1:0] s_awaddr;
    logic                       s_awvalid;
    logic                       s_awready;
    row_t                       s_wdata;
    logic                       s_wvalid;
    logic                       s_wready;
    logic [1:0]                 s_bresp;
    logic                       s_bvalid;
    logic                       s_bready;
    logic [axil_addr_width-1:0] s_araddr;
    logic                       s_arvalid;
    logic                       s_arready;
    row_t                       s_rdata;
    logic [1:0]                 s_rresp;
    logic                       s_rvalid;
    logic                       s_rready;
    op_ctrl_t                   op_ctrl_in;
    logic                       rd_cfg_vld;
    rd_cfg_t                    rd_cfg_in;
    gbus_wr_t                   gbus_in;
    sram_rd_t                   global_rd;
    sram_rd_t                   hlink_out;
    gbus_wr_t                   gbus_out;
    logic                       finish;

    row_t           model [sram_depth];  // expected sram contents
    control_state_t cur_state;
    int             checks = 0;
    int             errors = 0;
    int             tests  = 0;
    logic           hung   = 1'b0;       // a wait ran out

    head_tile i_head_tile (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic compare_row(input row_t got, input row_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_resp(input logic [1:0] got, input string what);
        checks++;
        if (got !== 2'b00) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected OKAY", $time, what, got);
        end
    endtask

    task automatic compare_gbus(input gbus_wr_t got, input gbus_wr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // bus and control drivers
    ////////////////////////////////////////

    task next_cycle;
        @(posedge clk);
        #2;  // drive point
    endtask

    task automatic host_write(input logic [5:0] row, input row_t data, input int stall);
        int n;
        s_awaddr  = {row, 2'b00};
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        n = 0;
        #1;
        compare_flag(s_awready, 1'b1, "awready with no response pending");
        compare_flag(s_wready, 1'b1, "wready with no response pending");
        next_cycle();
        while (!s_bvalid && n < hs_timeout) begin
            next_cycle();
            n++;
        end
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        if (!s_bvalid) begin
            $display("timeout: write to row %0d was never accepted", row);
            hung = 1'b1;
            return;
        end
        model[row] = data;
        repeat (stall) next_cycle();  // bready low so the response must hold
        compare_flag(s_bvalid, 1'b1, "bvalid held under back-pressure");
        compare_resp(s_bresp, "bresp");
        s_bready = 1'b1;
        n = 0;
        next_cycle();
        while (s_bvalid && n < hs_timeout) begin
            next_cycle();
            n++;
        end
        s_bready = 1'b0;
        if (s_bvalid) begin
            $display("timeout: bvalid did not drop after bready");
            hung = 1'b1;
        end
    endtask

    task automatic host_read(input logic [5:0] row, input row_t exp, input int stall);
        int   n;
        logic acc;
        s_araddr  = {row, 2'b00};
        s_arvalid = 1'b1;
        acc = 1'b0;
        n   = 0;
        while (!acc && n < hs_timeout) begin
            #1;
            acc = s_arready;  // taken at the coming edge
            next_cycle();
            n++;
        end
        s_arvalid = 1'b0;
        n = 0;
        while (acc && !s_rvalid && n < hs_timeout) begin
            next_cycle();
            n++;
        end
        if (!acc || !s_rvalid) begin
            $display("timeout: no read data for row %0d", row);
            hung = 1'b1;
            return;
        end
        compare_row(model[row], exp, "model row against test file");
        compare_row(s_rdata, exp, $sformatf("host read row %0d", row));
        compare_resp(s_rresp, "rresp");
        repeat (stall) next_cycle();
        compare_flag(s_rvalid, 1'b1, "rvalid held under back-pressure");
        compare_row(s_rdata, exp, "rdata held under back-pressure");
        s_rready = 1'b1;
        n = 0;
        next_cycle();
        while (s_rvalid && n < hs_timeout) begin
            next_cycle();
            n++;
        end
        s_rready = 1'b0;
        if (s_rvalid) begin
            $display("timeout: rvalid did not drop after rready");
            hung = 1'b1;
        end
    endtask

    task automatic set_state(input control_state_t st);
        op_ctrl_in.state  = st;
        op_ctrl_in.update = 1'b1;
        op_ctrl_in.start  = 1'b0;
        next_cycle();
        op_ctrl_in.update = 1'b0;
        cur_state = st;
    endtask

    task automatic elem_write(input logic [7:0] addr, input logic [7:0] data, input logic sel);
        gbus_wr_t   wr;
        logic [7:0] val;
        int         lane;
        wr.wen     = 1'b1;
        wr.hs_bias = sel;
        wr.addr    = addr;
        wr.data    = data;
        gbus_in = wr;
        next_cycle();
        gbus_in = '0;
        compare_gbus(gbus_out, wr, "gbus_out one cycle later");
        if (sel) begin
            // relu only in ffn0
            val  = (cur_state == ffn0 && data[7]) ? 8'h00 : data;
            lane = int'(addr[1:0]);
            model[addr[7:2]][lane*idata_width +: idata_width] = val;
        end
    endtask

    task automatic global_push(input row_t data);
        global_rd.data = data;
        global_rd.vld  = 1'b1;
        next_cycle();
        global_rd = '0;
        compare_flag(hlink_out.vld, 1'b1, "hlink valid on global push");
        compare_row(hlink_out.data, data, "hlink global row");
        next_cycle();
        compare_flag(hlink_out.vld, 1'b0, "hlink valid after global push");
    endtask

    task automatic run_op(input logic [5:0] base, input logic [6:0] cnt, input int busy);
        row_t       rows [$];
        int         cyc;
        int         last_wen;
        int         fin_cyc;
        int         finishes;
        int         late_rows;
        logic       bus_state;
        logic [5:0] ri;
        bus_state = cur_state inside {att_qk, att_pv, proj, ffn0, ffn1};
        cyc       = 0;
        last_wen  = -1;
        fin_cyc   = -1;
        finishes  = 0;
        late_rows = 0;
        rd_cfg_in.base_row = base;
        rd_cfg_in.row_cnt  = cnt;
        rd_cfg_vld         = 1'b1;
        op_ctrl_in.state   = cur_state;
        op_ctrl_in.start   = 1'b1;
        while (fin_cyc < 0 && cyc < op_timeout) begin
            if (cyc < busy) begin
                gbus_in.wen     = 1'b1;  // bus traffic not aimed at this head
                gbus_in.hs_bias = 1'b0;
                gbus_in.addr    = cyc[7:0];
                gbus_in.data    = 8'h5a;
            end else begin
                gbus_in = '0;
            end
            next_cycle();
            rd_cfg_vld       = 1'b0;
            op_ctrl_in.start = 1'b0;
            if (hlink_out.vld === 1'b1) rows.push_back(hlink_out.data);
            if (gbus_out.wen === 1'b1) last_wen = cyc;
            if (finish === 1'b1) begin
                finishes++;
                fin_cyc = cyc;
            end
            cyc++;
        end
        gbus_in = '0;
        if (fin_cyc < 0) begin
            $display("timeout: no finish pulse within %0d cycles of the start", op_timeout);
            hung = 1'b1;
            return;
        end
        repeat (6) begin
            next_cycle();
            if (hlink_out.vld !== 1'b0) late_rows++;
            if (finish !== 1'b0) finishes++;
        end
        compare_count(rows.size(), int'(cnt), "hlink rows in operation");
        compare_count(late_rows, 0, "hlink rows after finish");
        compare_count(finishes, 1, "finish pulses");
        for (int i = 0; i < rows.size() && i < int'(cnt); i++) begin
            ri = base + i[5:0];
            compare_row(rows[i], model[ri], $sformatf("hlink row %0d", i));
        end
        if (bus_state && busy > 0) begin
            compare_flag(fin_cyc > last_wen + 1, 1'b1, "finish after gbus went idle");
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %0d %s : %s", tests, name, (errors == err0 && !hung) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int         fd;
        int         n;
        int         err0;
        string      line;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        clk        = 1'b0;
        rst_n      = 1'b0;
        s_awaddr   = '0;
        s_awvalid  = 1'b0;
        s_wdata    = '0;
        s_wvalid   = 1'b0;
        s_bready   = 1'b0;
        s_araddr   = '0;
        s_arvalid  = 1'b0;
        s_rready   = 1'b0;
        op_ctrl_in = '0;
        rd_cfg_vld = 1'b0;
        rd_cfg_in  = '0;
        gbus_in    = '0;
        global_rd  = '0;
        cur_state  = idle;
        foreach (model[i]) model[i] = '0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        next_cycle();
        err0 = errors;
        compare_flag(s_bvalid, 1'b0, "bvalid after reset");
        compare_flag(s_rvalid, 1'b0, "rvalid after reset");
        compare_flag(s_awready, 1'b0, "awready after reset");
        compare_flag(s_wready, 1'b0, "wready after reset");
        compare_flag(s_arready, 1'b0, "arready after reset");
        compare_flag(hlink_out.vld, 1'b0, "hlink valid after reset");
        compare_flag(gbus_out.wen, 1'b0, "gbus_out wen after reset");
        compare_flag(finish, 1'b0, "finish after reset");
        report_test("reset", err0);

        fd = $fopen("tb/head_tile_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/head_tile_tests.txt");
            hung = 1'b1;
        end
        while (fd != 0 && !hung && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                err0 = errors;
                n = $sscanf(line, "%c %h %h %h", op, a, b, c);
                if (n != 4) begin
                    $display("malformed line in test file: %s", line);
                    errors++;
                end else begin
                    case (op)
                        "W": host_write(a[5:0], b, int'(c));
                        "R": host_read(a[5:0], b, int'(c));
                        "S": set_state(control_state_t'(a[3:0]));
                        "E": elem_write(a[7:0], b[7:0], c[0]);
                        "O": run_op(a[5:0], b[6:0], int'(c));
                        "G": global_push(a);
                        default: begin
                            $display("unknown command %c in test file", op);
                            errors++;
                        end
                    endcase
                end
                report_test($sformatf("%c %h %h %h", op, a, b, c), err0);
            end
        end
        if (fd != 0) $fclose(fd);

        $display("tests %0d, checks %0d, errors %0d, timeout %0d", tests, checks, errors, hung);
        if (errors == 0 && !hung) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
